/* exec_macros.svh */
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// data path width
`define EXEC_XLEN 32

// major opcodes, instr[6:0]
`define EXEC_OPC_LUI    7'b0110111
`define EXEC_OPC_AUIPC  7'b0010111
`define EXEC_OPC_LOAD   7'b0000011
`define EXEC_OPC_STORE  7'b0100011
`define EXEC_OPC_OPIMM  7'b0010011
`define EXEC_OPC_OP     7'b0110011

// funct7 values, instr[31:25]
`define EXEC_F7_BASE    7'b0000000
`define EXEC_F7_ALT     7'b0100000  // sub, sra, srai
`define EXEC_F7_COUNT   7'b0110000  // clz, ctz, cpop

`endif

/* exec_pkg.sv */
`include "exec_macros.svh"

package exec_pkg;

    // operation select between decoder and alu
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_SLTU   = 4'd9,
        ALU_PASS_A = 4'd10,  // lui
        ALU_CLZ    = 4'd11,
        ALU_CTZ    = 4'd12,
        ALU_CPOP   = 4'd13
    } alu_op_e;

    // bundle from the decode stage
    typedef struct packed {
        logic [`EXEC_XLEN-1:0] instr;
        logic [`EXEC_XLEN-1:0] pc;
        logic [`EXEC_XLEN-1:0] rs1;  // register file read values
        logic [`EXEC_XLEN-1:0] rs2;
        logic                  prio; // first of a parallel pair
    } id_ex_s;

    // forwarding choice from the hazard unit, one per operand
    typedef struct packed {
        logic                  rs1_en;
        logic [`EXEC_XLEN-1:0] rs1_val;
        logic                  rs2_en;
        logic [`EXEC_XLEN-1:0] rs2_val;
    } fwd_s;

    typedef struct packed {
        alu_op_e               op;
        logic [`EXEC_XLEN-1:0] a;
        logic [`EXEC_XLEN-1:0] b;
    } alu_req_s;

    // execute/memory boundary
    typedef struct packed {
        logic [`EXEC_XLEN-1:0] pc;
        logic [`EXEC_XLEN-1:0] instr;
        logic [`EXEC_XLEN-1:0] result;     // alu output, also the memory address
        logic [`EXEC_XLEN-1:0] store_data;
        logic                  reg_wr_en;
        logic                  mem_en;     // store request
        logic                  prio;
    } exmem_s;

endpackage

/* exec_alu.sv */
`include "exec_macros.svh"

module exec_alu import exec_pkg::*; (
    input  alu_req_s               req_i,
    output logic [`EXEC_XLEN-1:0] result_o
);

    localparam int XLEN = `EXEC_XLEN;
    localparam int SHW  = $clog2(XLEN);

    logic [SHW-1:0] sh_amt;

    // leading zeros, full width for a zero operand
    function automatic logic [XLEN-1:0] count_lz(input logic [XLEN-1:0] v);
        logic [XLEN-1:0] cnt;
        logic            done;
        cnt  = '0;
        done = 1'b0;
        for (int i = XLEN - 1; i >= 0; i--) begin
            if (v[i]) begin
                done = 1'b1;
            end else if (!done) begin
                cnt = cnt + 1'b1;
            end
        end
        return cnt;
    endfunction

    function automatic logic [XLEN-1:0] count_tz(input logic [XLEN-1:0] v);
        logic [XLEN-1:0] cnt;
        logic            done;
        cnt  = '0;
        done = 1'b0;
        for (int i = 0; i < XLEN; i++) begin
            if (v[i]) begin
                done = 1'b1;
            end else if (!done) begin
                cnt = cnt + 1'b1;
            end
        end
        return cnt;
    endfunction

    function automatic logic [XLEN-1:0] count_pop(input logic [XLEN-1:0] v);
        logic [XLEN-1:0] cnt;
        cnt = '0;
        for (int i = 0; i < XLEN; i++) begin
            if (v[i]) begin
                cnt = cnt + 1'b1;
            end
        end
        return cnt;
    endfunction

    assign sh_amt = req_i.b[SHW-1:0]; // only the low bits count

    always_comb begin
        case (req_i.op)
            ALU_ADD:    result_o = req_i.a + req_i.b;
            ALU_SUB:    result_o = req_i.a - req_i.b;
            ALU_AND:    result_o = req_i.a & req_i.b;
            ALU_OR:     result_o = req_i.a | req_i.b;
            ALU_XOR:    result_o = req_i.a ^ req_i.b;
            ALU_SLL:    result_o = req_i.a << sh_amt;
            ALU_SRL:    result_o = req_i.a >> sh_amt;
            ALU_SRA:    result_o = $unsigned($signed(req_i.a) >>> sh_amt);
            ALU_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, $signed(req_i.a) < $signed(req_i.b)};
            end
            ALU_SLTU:   result_o = {{(XLEN-1){1'b0}}, req_i.a < req_i.b};
            ALU_PASS_A: result_o = req_i.a;
            ALU_CLZ:    result_o = count_lz(req_i.a);
            ALU_CTZ:    result_o = count_tz(req_i.a);
            ALU_CPOP:   result_o = count_pop(req_i.a);
            default:    result_o = '0;  // unused encodings
        endcase
    end

endmodule

/* exec_decoder.sv */
`include "exec_macros.svh"

module exec_decoder import exec_pkg::*; (
    input  id_ex_s   id_i,
    input  fwd_s     fwd_i,
    output alu_req_s alu_req_o,
    output exmem_s   ex_data_o
);

    localparam int XLEN = `EXEC_XLEN;

    logic [XLEN-1:0] rs1_op;
    logic [XLEN-1:0] rs2_op;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] shamt;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [4:0]      rs2_fld;

    alu_op_e         op_sel;
    logic [XLEN-1:0] opa;
    logic [XLEN-1:0] opb;
    logic            wr_en;
    logic            st_en;
    logic            hit;

    // funct3 to operation, shared by op and op-imm
    function automatic alu_op_e base_op(input logic [2:0] f3);
        alu_op_e res;
        unique case (f3)
            3'b000:  res = ALU_ADD;
            3'b001:  res = ALU_SLL;
            3'b010:  res = ALU_SLT;
            3'b011:  res = ALU_SLTU;
            3'b100:  res = ALU_XOR;
            3'b101:  res = ALU_SRL;
            3'b110:  res = ALU_OR;
            default: res = ALU_AND;
        endcase
        return res;
    endfunction

    // forwarded value wins over the register file read
    assign rs1_op = fwd_i.rs1_en ? fwd_i.rs1_val : id_i.rs1;
    assign rs2_op = fwd_i.rs2_en ? fwd_i.rs2_val : id_i.rs2;

    assign opcode  = id_i.instr[6:0];
    assign funct3  = id_i.instr[14:12];
    assign funct7  = id_i.instr[31:25];
    assign rs2_fld = id_i.instr[24:20];

    assign imm_i = {{20{id_i.instr[31]}}, id_i.instr[31:20]};
    assign imm_s = {{20{id_i.instr[31]}}, id_i.instr[31:25], id_i.instr[11:7]};
    assign imm_u = {id_i.instr[31:12], 12'b0};
    assign shamt = {{(XLEN-5){1'b0}}, rs2_fld}; // shift immediate

    always_comb begin
        op_sel = ALU_ADD; // 0 + 0 for a bubble
        opa    = '0;
        opb    = '0;
        wr_en  = 1'b0;
        st_en  = 1'b0;
        hit    = 1'b0;

        case (opcode)
            `EXEC_OPC_LUI: begin
                op_sel = ALU_PASS_A;
                opa    = imm_u;
                wr_en  = 1'b1;
            end
            `EXEC_OPC_AUIPC: begin
                opa   = id_i.pc;
                opb   = imm_u;
                wr_en = 1'b1;
            end
            `EXEC_OPC_LOAD: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                    opa   = rs1_op;
                    opb   = imm_i;
                    wr_en = 1'b1;
                end
            end
            `EXEC_OPC_STORE: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
                    opa   = rs1_op;
                    opb   = imm_s;
                    st_en = 1'b1;
                end
            end
            `EXEC_OPC_OPIMM: begin
                case (funct3)
                    3'b001: begin
                        if (funct7 == `EXEC_F7_BASE) begin // slli
                            op_sel = ALU_SLL;
                            opb    = shamt;
                            hit    = 1'b1;
                        end else if (funct7 == `EXEC_F7_COUNT && rs2_fld <= 5'd2) begin
                            op_sel = (rs2_fld == 5'd0) ? ALU_CLZ :
                                     (rs2_fld == 5'd1) ? ALU_CTZ : ALU_CPOP;
                            hit    = 1'b1;
                        end
                    end
                    3'b101: begin
                        if (funct7 == `EXEC_F7_BASE || funct7 == `EXEC_F7_ALT) begin
                            op_sel = (funct7 == `EXEC_F7_ALT) ? ALU_SRA : ALU_SRL;
                            opb    = shamt;
                            hit    = 1'b1;
                        end
                    end
                    default: begin
                        op_sel = base_op(funct3);
                        opb    = imm_i;
                        hit    = 1'b1;
                    end
                endcase
                if (hit) begin
                    opa   = rs1_op;
                    wr_en = 1'b1;
                end else begin
                    op_sel = ALU_ADD;
                    opb    = '0;
                end
            end
            `EXEC_OPC_OP: begin
                if (funct7 == `EXEC_F7_BASE) begin
                    op_sel = base_op(funct3);
                    hit    = 1'b1;
                end else if (funct7 == `EXEC_F7_ALT && funct3 inside {3'b000, 3'b101}) begin
                    op_sel = (funct3 == 3'b000) ? ALU_SUB : ALU_SRA;
                    hit    = 1'b1;
                end
                if (hit) begin
                    opa   = rs1_op;
                    opb   = rs2_op;
                    wr_en = 1'b1;
                end
            end
            default: ;  // unsupported opcode, bubble
        endcase
    end

    assign alu_req_o.op = op_sel;
    assign alu_req_o.a  = opa;
    assign alu_req_o.b  = opb;

    always_comb begin
        ex_data_o            = '0;
        ex_data_o.pc         = id_i.pc;
        ex_data_o.instr      = id_i.instr;
        ex_data_o.store_data = st_en ? rs2_op : '0;
        ex_data_o.reg_wr_en  = wr_en;
        ex_data_o.mem_en     = st_en;
        ex_data_o.prio       = id_i.prio;
    end

endmodule

/* exmem_reg.sv */
module exmem_reg import exec_pkg::*; (
    input  logic   clk_i,
    input  logic   rstn_i,
    input  logic   flush_i,
    input  exmem_s ex_data_i,
    output exmem_s exmem_o
);

    logic kill;

    // a prio instruction is older than the branch and survives the flush
    assign kill = flush_i && !ex_data_i.prio;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            exmem_o <= '0;
        end else if (kill) begin
            exmem_o <= '0;          // bubble into memory stage
        end else begin
            exmem_o <= ex_data_i;
        end
    end

    // memory stage sees either a store or a write-back, never both
    a_enables_excl: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !(exmem_o.reg_wr_en && exmem_o.mem_en)
    ) else $error("exmem_o carries mem_en and reg_wr_en together");

endmodule

/* execute_stage.sv */
`include "exec_macros.svh"

module execute_stage import exec_pkg::*; (
    input  logic   clk_i,
    input  logic   rstn_i,
    input  logic   flush_i,
    input  id_ex_s id_i,
    input  fwd_s   fwd_i,
    output exmem_s exmem_o
);

    alu_req_s              alu_req;
    logic [`EXEC_XLEN-1:0] alu_result;
    exmem_s                ex_data;     // from decoder, result still empty
    exmem_s                ex_full;

    exec_decoder decoder_i (
        .id_i      (id_i),
        .fwd_i     (fwd_i),
        .alu_req_o (alu_req),
        .ex_data_o (ex_data)
    );

    exec_alu alu_i (
        .req_i    (alu_req),
        .result_o (alu_result)
    );

    always_comb begin
        ex_full        = ex_data;
        ex_full.result = alu_result; // address for loads and stores
    end

    exmem_reg exmem_reg_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .flush_i   (flush_i),
        .ex_data_i (ex_full),
        .exmem_o   (exmem_o)
    );

endmodule

/* tb_execute_stage.sv */
`include "exec_macros.svh"

module tb_execute_stage import exec_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int OP_REPS      = 3;   // per funct3/funct7 pair
    localparam int OPIMM_REPS   = 12;
    localparam int MEM_REPS     = 4;
    localparam int FWD_REPS     = 4;
    localparam int FLUSH_CYCLES = 16;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 1 + OP_REPS * 32 + OPIMM_REPS * 8
                                + MEM_REPS * 19 + FWD_REPS * 8 + FLUSH_CYCLES;
    localparam int WATCHDOG_CYCLES = TOTAL_CYCLES + 100; // slack for gaps between tests

    logic   clk_i = 1'b0;
    logic   rstn_i;
    logic   flush_i;
    id_ex_s id_i;
    fwd_s   fwd_i;
    exmem_s exmem_o;

    integer seed = 32'h856f_f794;
    exmem_s exp_q[$];
    string  name_q[$];
    int     pending  = 0;
    int     pass_cnt = 0;
    int     err_cnt  = 0;
    int     t_checks = 0;
    int     t_errs   = 0;
    string  test_name;

    execute_stage execute_stage_i (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .flush_i (flush_i),
        .id_i    (id_i),
        .fwd_i   (fwd_i),
        .exmem_o (exmem_o)
    );

    initial begin
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    // mostly random, sometimes the corner values for the bit counters
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = rnd();
        case (r[1:0])
            2'd0:    return 32'h0000_0000;
            2'd1:    return 32'hffff_ffff;
            default: return rnd();
        endcase
    endfunction

    // register fields random, upper bits and funct3 given
    function automatic logic [31:0] make_instr(input logic [6:0] hi7, input logic [4:0] f5,
                                               input logic [2:0] f3, input logic [6:0] opc);
        logic [31:0] r;
        r = rnd();
        return {hi7, f5, r[19:15], f3, r[11:7], opc};
    endfunction

    function automatic logic [31:0] bit_count(input logic [31:0] v, input logic [4:0] kind);
        int n;
        n = 0;
        case (kind)
            5'd0: while (n < 32 && !v[31-n]) n++;  // leading zeros
            5'd1: while (n < 32 && !v[n]) n++;     // trailing zeros
            default: begin
                for (int i = 0; i < 32; i++) begin
                    if (v[i]) n++;
                end
            end
        endcase
        return n;
    endfunction

    // rv32i arithmetic by funct3, alt selects sub and sra
    function automatic logic [31:0] calc(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // expected exmem contents one edge after presenting id and fw
    function automatic exmem_s ref_model(input id_ex_s id, input fwd_s fw, input logic flush);
        exmem_s      e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ins;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [4:0]  fld;
        e = '0;
        if (flush && !id.prio) return e;
        ins   = id.instr;
        a     = fw.rs1_en ? fw.rs1_val : id.rs1;
        b     = fw.rs2_en ? fw.rs2_val : id.rs2;
        f3    = ins[14:12];
        f7    = ins[31:25];
        fld   = ins[24:20];
        imm_i = 32'($signed(ins[31:20]));
        imm_s = 32'($signed({ins[31:25], ins[11:7]}));
        e.pc    = id.pc;
        e.instr = ins;
        e.prio  = id.prio;
        case (ins[6:0])
            `EXEC_OPC_LUI: begin
                e.result    = {ins[31:12], 12'h000};
                e.reg_wr_en = 1'b1;
            end
            `EXEC_OPC_AUIPC: begin
                e.result    = id.pc + {ins[31:12], 12'h000};
                e.reg_wr_en = 1'b1;
            end
            `EXEC_OPC_LOAD: if (f3 != 3'b011 && f3 < 3'b110) begin  // lb lh lw lbu lhu
                e.result    = a + imm_i;
                e.reg_wr_en = 1'b1;
            end
            `EXEC_OPC_STORE: if (f3 < 3'b011) begin
                e.result     = a + imm_s;
                e.store_data = b;
                e.mem_en     = 1'b1;
            end
            `EXEC_OPC_OPIMM: begin
                if (f3 == 3'b001 && f7 == `EXEC_F7_BASE) begin
                    e.result    = a << fld;
                    e.reg_wr_en = 1'b1;
                end else if (f3 == 3'b001 && f7 == `EXEC_F7_COUNT && fld < 5'd3) begin
                    e.result    = bit_count(a, fld);
                    e.reg_wr_en = 1'b1;
                end else if (f3 == 3'b101 && (f7 == `EXEC_F7_BASE || f7 == `EXEC_F7_ALT)) begin
                    e.result    = calc(f3, f7 == `EXEC_F7_ALT, a, {27'd0, fld});
                    e.reg_wr_en = 1'b1;
                end else if (f3 != 3'b001 && f3 != 3'b101) begin
                    e.result    = calc(f3, 1'b0, a, imm_i);
                    e.reg_wr_en = 1'b1;
                end
            end
            `EXEC_OPC_OP: begin
                if (f7 == `EXEC_F7_BASE || (f7 == `EXEC_F7_ALT && f3 inside {3'b000, 3'b101})) begin
                    e.result    = calc(f3, f7 == `EXEC_F7_ALT, a, b);
                    e.reg_wr_en = 1'b1;
                end
            end
            default: ;
        endcase
        return e;
    endfunction

    task automatic drive(input id_ex_s id, input fwd_s fw, input logic fl, input exmem_s exp);
        id_i    = id;
        fwd_i   = fw;
        flush_i = fl;
        exp_q.push_back(exp);
        name_q.push_back(test_name);
        pending++;
    endtask

    task automatic apply(input logic [31:0] instr, input fwd_s fw, input logic fl,
                         input logic pr);
        id_ex_s      id;
        logic [31:0] pc_r;
        pc_r     = rnd();
        id.instr = instr;
        id.pc    = {pc_r[31:2], 2'b00};
        id.rs1   = pick_operand();
        id.rs2   = pick_operand();
        id.prio  = pr;
        @(negedge clk_i);
        drive(id, fw, fl, ref_model(id, fw, fl));
    endtask

    task automatic start_test(input string name);
        test_name = name;
        t_checks  = 0;
        t_errs    = 0;
    endtask

    task automatic end_test();
        wait (pending == 0);
        $display("test %-8s done: %0d checks, %0d errors", test_name, t_checks, t_errs);
    endtask

    // compares a quarter period after the edge, once exmem_o has settled
    initial begin
        exmem_s exp;
        string  nm;
        logic   ok;
        forever begin
            @(posedge clk_i);
            #(CLK_PERIOD / 4);
            if (pending > 0) begin
                exp = exp_q.pop_front();
                nm  = name_q.pop_front();
                ok  = (exmem_o === exp);
                t_checks++;
                assert (ok) else begin
                    err_cnt++;
                    t_errs++;
                    $display("** Error %s: expected %h, actual %h", nm, exp, exmem_o);
                end
                if (ok) pass_cnt++;
                pending--;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run still busy after %0d clock cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        id_ex_s      id;
        fwd_s        fw;
        logic [6:0]  op_f7 [4];
        logic [31:0] r;
        op_f7 = '{`EXEC_F7_BASE, `EXEC_F7_ALT, `EXEC_F7_COUNT, 7'b0000001};
        rstn_i  = 1'b0;
        flush_i = 1'b0;
        id_i    = '0;
        fwd_i   = '0;

        start_test("reset");
        for (int i = 0; i < RESET_CYCLES; i++) begin
            if (i > 0) @(negedge clk_i);
            id = {rnd(), rnd(), rnd(), rnd(), 1'b1};
            fw = {1'b1, rnd(), 1'b1, rnd()};
            drive(id, fw, 1'b0, '0);   // garbage in, zeros out
        end
        @(negedge clk_i);
        rstn_i = 1'b1;
        drive('0, '0, 1'b0, '0);
        end_test();

        start_test("op");
        for (int k = 0; k < 4; k++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                repeat (OP_REPS) apply(make_instr(op_f7[k], rnd(), f3, `EXEC_OPC_OP), '0, 0, 0);
            end
        end
        end_test();

        start_test("op_imm");
        for (int rep = 0; rep < OPIMM_REPS; rep++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                r = rnd();
                if (f3 == 1 && rep % 5 == 0) begin
                    apply(make_instr(`EXEC_F7_BASE, r[4:0], 3'b001, `EXEC_OPC_OPIMM), '0, 0, 0);
                end else if (f3 == 1) begin
                    // clz, ctz, cpop and one unused selector
                    apply(make_instr(`EXEC_F7_COUNT, rep % 5 - 1, 3'b001, `EXEC_OPC_OPIMM),
                          '0, 0, 0);
                end else if (f3 == 5) begin
                    apply(make_instr(rep[0] ? `EXEC_F7_ALT : `EXEC_F7_BASE, r[4:0], 3'b101,
                                     `EXEC_OPC_OPIMM), '0, 0, 0);
                end else begin
                    apply(make_instr(r[6:0], r[11:7], f3, `EXEC_OPC_OPIMM), '0, 0, 0);
                end
            end
        end
        end_test();

        start_test("mem");
        for (int rep = 0; rep < MEM_REPS; rep++) begin
            apply(rnd() & 32'hffff_f000 | `EXEC_OPC_LUI, '0, 0, 0);
            apply(rnd() & 32'hffff_f000 | `EXEC_OPC_AUIPC, '0, 0, 0);
            for (int f3 = 0; f3 < 8; f3++) begin
                r = rnd();
                apply(make_instr(r[6:0], r[11:7], f3, `EXEC_OPC_LOAD), '0, 0, 0);
                apply(make_instr(r[6:0], r[11:7], f3, `EXEC_OPC_STORE), '0, 0, 0);
            end
            apply(rnd() & 32'hffff_ff80 | 7'b1110011, '0, 0, 0); // system, not decoded
        end
        end_test();

        start_test("forward");
        for (int c = 0; c < 4; c++) begin
            repeat (FWD_REPS) begin
                fw = {c[0] == 1'b1, pick_operand(), c[1] == 1'b1, pick_operand()};
                apply(make_instr(`EXEC_F7_BASE, rnd(), 3'b000, `EXEC_OPC_OP), fw, 0, 0);
                apply(make_instr(rnd(), rnd(), 3'b010, `EXEC_OPC_STORE), fw, 0, 0);
            end
        end
        end_test();

        start_test("flush");
        for (int i = 0; i < FLUSH_CYCLES; i++) begin
            r = rnd();
            apply(make_instr(`EXEC_F7_BASE, r[4:0], r[14:12],
                             r[15] ? `EXEC_OPC_OP : `EXEC_OPC_STORE),
                  '0, i % 4 != 3, i[0]);
        end
        end_test();

        $display("checks passed: %0d, errors: %0d", pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+.
exec_pkg.sv
exec_alu.sv
exec_decoder.sv
exmem_reg.sv
execute_stage.sv
tb_execute_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_execute_stage
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) exec_macros.svh

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
